//--- gcm_aes.f
+incdir+src
src/gcm_aes_pkg.sv
src/gcm_cfg_regs.sv
src/aes256_round_engine.sv
src/ghash_mult.sv
src/gcm_sequencer.sv
src/gcm_aes_top.sv
bench/tb_gcm_aes.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_gcm_aes
FILELIST   ?= gcm_aes.f
BUILD_DIR  ?= build
LOG        ?= $(BUILD_DIR)/sim.log
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert
PASS_TEXT  ?= === PASS ===
SRCS       := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard src/*.svh)
SIM_BIN    := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_gcm_aes.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module tb_gcm_aes;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int STEP_CYCLES  = 200;     // Budget per key load or message
    localparam int N_STEPS      = 12;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + STEP_CYCLES * N_STEPS) * CLK_PERIOD;
    localparam int NB_CT        = `GCM_N_BLOCKS * `GCM_NB_BLOCK;
    localparam logic [1:0] TAG_SKIP = 2'd0;
    localparam logic [1:0] TAG_SAME = 2'd1;
    localparam logic [1:0] TAG_DIFF = 2'd2;
    // Known answers for key zero and IV zero
    localparam logic [`GCM_NB_BLOCK-1:0] KS0_ZERO      = 128'hcea7403d4d606b6e074ec5d3baf39d18;
    localparam logic [`GCM_NB_BLOCK-1:0] TAG_EMPTY     = 128'h530f8afbc74536b9a963b4f1c4cb738b;
    localparam logic [`GCM_NB_BLOCK-1:0] TAG_ONE_BLOCK = 128'hd0d1c8a799996bf0265b98b5d48ab919;

    logic                     tb_i_clock;
    logic                     i_arst_n;
    logic                     i_cfg_load;
    gcm_aes_pkg::gcm_cfg_t    i_cfg;
    logic                     i_valid;
    gcm_aes_pkg::gcm_msg_t    i_msg;
    logic                     o_busy;
    logic                     o_valid;
    logic [NB_CT-1:0]         o_ciphertext;
    gcm_aes_pkg::aes_block_t  o_tag;

    logic [31:0]              lcg_state;
    logic [NB_CT-1:0]         exp_ct;
    logic [NB_CT-1:0]         exp_mask;     // Ciphertext bits that are known
    gcm_aes_pkg::aes_block_t  exp_tag;
    logic [1:0]               tag_mode;
    logic                     cfg_loaded;
    int                       n_sent;
    int                       n_seen = 0;
    logic [NB_CT-1:0]         pt_a;
    logic [NB_CT-1:0]         pt_b;
    logic [NB_CT-1:0]         keystream;
    logic [`GCM_NB_KEY-1:0]   key_other;
    gcm_aes_pkg::aes_block_t  blk;
    gcm_aes_pkg::aes_block_t  aad_c;
    gcm_aes_pkg::aes_block_t  tag_a;
    gcm_aes_pkg::aes_block_t  tag_b;
    gcm_aes_pkg::aes_block_t  tag_c;

    gcm_aes_top i_dut (
        .tb_i_clock   (tb_i_clock),
        .i_arst_n     (i_arst_n),
        .i_cfg_load   (i_cfg_load),
        .i_cfg        (i_cfg),
        .i_valid      (i_valid),
        .i_msg        (i_msg),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_ciphertext (o_ciphertext),
        .o_tag        (o_tag)
    );

    always #(CLK_PERIOD / 2) tb_i_clock = ~tb_i_clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic fail_mismatch(input string what);
        abort_run($sformatf("Mismatch at time %0t: %s", $time, what));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_block(output gcm_aes_pkg::aes_block_t b);
        for (int i = 0; i < 4; i++)
        begin
            lcg_state     = lcg_next(lcg_state);
            b[32*i +: 32] = lcg_state;
        end
    endtask

    function automatic gcm_aes_pkg::gcm_msg_t make_msg(
        input gcm_aes_pkg::aes_block_t aad,
        input logic [NB_CT-1:0]        pt,
        input logic [`GCM_NB_LEN-1:0]  len_aad,
        input logic [`GCM_NB_LEN-1:0]  len_pt
    );
        gcm_aes_pkg::gcm_msg_t m;
        m.aad       = aad;
        m.plaintext = pt;
        m.len_aad   = len_aad;
        m.len_pt    = len_pt;
        return m;
    endfunction

    task automatic set_expect(input logic [NB_CT-1:0] ct, input logic [NB_CT-1:0] mask,
                              input gcm_aes_pkg::aes_block_t tag, input logic [1:0] mode);
        exp_ct   = ct;
        exp_mask = mask;
        exp_tag  = tag;
        tag_mode = mode;
    endtask

    task automatic load_config(input logic [`GCM_NB_KEY-1:0] key,
                               input logic [`GCM_NB_IV-1:0] iv);
        int cycles;
        cycles = 0;
        @(negedge tb_i_clock);
        i_cfg.key  = key;
        i_cfg.iv   = iv;
        i_cfg_load = 1'b1;
        cfg_loaded = 1'b1;
        @(negedge tb_i_clock);
        i_cfg_load = 1'b0;
        busy_after_load: assert (o_busy)
            else abort_run("DUT did not start the hash subkey after a key load");
        while (o_busy)
        begin
            if (cycles == STEP_CYCLES)
                abort_run("Hash subkey computation did not finish in time");
            else
            begin
                cycles++;
                @(negedge tb_i_clock);
            end
        end
    endtask

    // With poke_busy a second strobe is driven while the core is working
    task automatic send_message(input gcm_aes_pkg::gcm_msg_t msg, input logic poke_busy);
        int cycles;
        cycles = 0;
        @(negedge tb_i_clock);
        i_msg   = msg;
        i_valid = 1'b1;
        n_sent++;
        @(negedge tb_i_clock);
        i_valid = 1'b0;
        if (poke_busy)
        begin
            repeat (3) @(negedge tb_i_clock);
            busy_at_poke: assert (o_busy)
                else abort_run("DUT was idle when the strobe during a message was driven");
            i_valid = 1'b1;
            @(negedge tb_i_clock);
            i_valid = 1'b0;
        end
        while (!o_valid)
        begin
            if (cycles == STEP_CYCLES)
                abort_run("No output pulse arrived for a message");
            else
            begin
                cycles++;
                @(negedge tb_i_clock);
            end
        end
        @(negedge tb_i_clock);      // Outputs held while the checks sample them
    endtask

    ct_check: assert property (@(posedge tb_i_clock) disable iff (!i_arst_n)
        o_valid |-> ((o_ciphertext & exp_mask) == (exp_ct & exp_mask)))
        else fail_mismatch($sformatf("ciphertext %h, expected %h under mask %h",
                                     o_ciphertext, exp_ct, exp_mask));

    tag_same: assert property (@(posedge tb_i_clock) disable iff (!i_arst_n)
        (o_valid && (tag_mode == TAG_SAME)) |-> (o_tag == exp_tag))
        else fail_mismatch($sformatf("tag %h, expected %h", o_tag, exp_tag));

    tag_diff: assert property (@(posedge tb_i_clock) disable iff (!i_arst_n)
        (o_valid && (tag_mode == TAG_DIFF)) |-> (o_tag != exp_tag))
        else fail_mismatch($sformatf("tag %h repeats a tag that should differ", o_tag));

    idle_before_load: assert property (@(posedge tb_i_clock) disable iff (!i_arst_n)
        o_busy |-> cfg_loaded)
        else abort_run("DUT went busy before any key load");

    // Each accepted message gives exactly one pulse
    always @(negedge tb_i_clock)
    begin
        if (i_arst_n && o_valid)
        begin
            pulse_count: assert (n_seen < n_sent)
                else abort_run("DUT produced an output pulse with no accepted message");
            n_seen <= n_seen + 1;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the tests completed");
    end

    initial
    begin
        tb_i_clock = 1'b0;
        i_arst_n   = 1'b0;
        i_cfg_load = 1'b0;
        i_cfg      = '0;
        i_valid    = 1'b0;
        i_msg      = '0;
        lcg_state  = 32'haaac;
        cfg_loaded = 1'b0;
        n_sent     = 0;
        set_expect('0, '0, '0, TAG_SKIP);
        repeat (RESET_CYCLES) @(posedge tb_i_clock);
        @(negedge tb_i_clock);
        i_arst_n = 1'b1;

        // No key yet, so this strobe must be dropped
        repeat (3) @(negedge tb_i_clock);
        i_msg   = make_msg('0, '0, '0, 64'd128);
        i_valid = 1'b1;
        @(negedge tb_i_clock);
        i_valid = 1'b0;
        repeat (30) @(negedge tb_i_clock);

        load_config('0, '0);
        set_expect('0, '1, TAG_EMPTY, TAG_SAME);
        send_message(make_msg('0, '0, '0, '0), 1'b0);
        set_expect({128'd0, KS0_ZERO}, '1, TAG_ONE_BLOCK, TAG_SAME);
        send_message(make_msg('0, '0, '0, 64'd128), 1'b0);

        // CTR keystream is the same for every message under one key and IV
        draw_block(blk);
        pt_a[127:0] = blk;
        draw_block(blk);
        pt_a[255:128] = blk;
        set_expect({128'd0, pt_a[127:0] ^ KS0_ZERO}, {128'd0, {128{1'b1}}}, '0, TAG_SKIP);
        send_message(make_msg('0, pt_a, '0, 64'd256), 1'b0);
        keystream = o_ciphertext ^ pt_a;
        tag_a     = o_tag;
        draw_block(blk);
        pt_b[127:0] = blk;
        draw_block(blk);
        pt_b[255:128] = blk;
        set_expect(pt_b ^ keystream, '1, tag_a, TAG_DIFF);
        send_message(make_msg('0, pt_b, '0, 64'd256), 1'b0);
        tag_b = o_tag;

        // AAD only reaches the tag
        draw_block(aad_c);
        set_expect(pt_b ^ keystream, '1, tag_b, TAG_DIFF);
        send_message(make_msg(aad_c, pt_b, 64'd128, 64'd256), 1'b0);
        tag_c = o_tag;
        set_expect(pt_b ^ keystream, '1, tag_c, TAG_SAME);
        send_message(make_msg(aad_c, pt_b, 64'd128, 64'd256), 1'b1);
        repeat (30) @(negedge tb_i_clock);

        // H must be rebuilt on each load
        draw_block(blk);
        key_other[127:0] = blk;
        draw_block(blk);
        key_other[255:128] = blk;
        draw_block(blk);
        load_config(key_other, blk[`GCM_NB_IV-1:0]);
        set_expect('0, '0, TAG_ONE_BLOCK, TAG_DIFF);
        send_message(make_msg('0, '0, '0, 64'd128), 1'b0);
        load_config('0, '0);
        set_expect({128'd0, KS0_ZERO}, '1, TAG_ONE_BLOCK, TAG_SAME);
        send_message(make_msg('0, '0, '0, 64'd128), 1'b0);
        repeat (30) @(negedge tb_i_clock);

        if (n_seen == n_sent)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
            abort_run("Not every accepted message produced an output pulse");
    end

endmodule

`default_nettype wire

//--- src/gcm_aes_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module gcm_aes_top (
    input  wire logic                                 tb_i_clock,
    input  wire logic                                 i_arst_n,
    input  wire logic                                 i_cfg_load,
    input  wire gcm_aes_pkg::gcm_cfg_t                i_cfg,
    input  wire logic                                 i_valid,
    input  wire gcm_aes_pkg::gcm_msg_t                i_msg,
    output logic                                      o_busy,
    output logic                                      o_valid,
    output logic [`GCM_N_BLOCKS*`GCM_NB_BLOCK-1:0]    o_ciphertext,
    output gcm_aes_pkg::aes_block_t                   o_tag
);

    logic [`GCM_NB_KEY-1:0]   key;
    logic [`GCM_NB_IV-1:0]    iv;
    gcm_aes_pkg::aes_block_t  h;
    gcm_aes_pkg::aes_block_t  aes_in;
    gcm_aes_pkg::aes_block_t  aes_out;
    gcm_aes_pkg::aes_block_t  mult_x;
    gcm_aes_pkg::aes_block_t  mult_h;
    gcm_aes_pkg::aes_block_t  mult_z;
    logic                     h_valid;
    logic                     h_store;
    logic                     aes_start;
    logic                     aes_done;
    logic                     cfg_load_ok;

    assign cfg_load_ok = i_cfg_load & ~o_busy;   // Loads while busy are dropped

    gcm_cfg_regs i_cfg_regs (
        .tb_i_clock (tb_i_clock),
        .i_arst_n   (i_arst_n),
        .i_cfg_load (cfg_load_ok),
        .i_cfg      (i_cfg),
        .i_h_store  (h_store),
        .i_h        (aes_out),
        .o_key      (key),
        .o_iv       (iv),
        .o_h        (h),
        .o_h_valid  (h_valid)
    );

    aes256_round_engine i_engine (
        .tb_i_clock (tb_i_clock),
        .i_arst_n   (i_arst_n),
        .i_start    (aes_start),
        .i_block    (aes_in),
        .i_key      (key),
        .o_done     (aes_done),
        .o_block    (aes_out)
    );

    ghash_mult i_mult (
        .i_x (mult_x),
        .i_h (mult_h),
        .o_z (mult_z)
    );

    gcm_sequencer i_seq (
        .tb_i_clock   (tb_i_clock),
        .i_arst_n     (i_arst_n),
        .i_cfg_load   (cfg_load_ok),
        .i_valid      (i_valid),
        .i_msg        (i_msg),
        .i_iv         (iv),
        .i_h          (h),
        .i_h_valid    (h_valid),
        .i_aes_done   (aes_done),
        .i_aes_block  (aes_out),
        .i_mult_z     (mult_z),
        .o_aes_start  (aes_start),
        .o_aes_block  (aes_in),
        .o_h_store    (h_store),
        .o_mult_x     (mult_x),
        .o_mult_h     (mult_h),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_ciphertext (o_ciphertext),
        .o_tag        (o_tag)
    );

endmodule

`default_nettype wire

//--- src/gcm_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module gcm_sequencer (
    input  wire logic                                     tb_i_clock,
    input  wire logic                                     i_arst_n,
    input  wire logic                                     i_cfg_load,
    input  wire logic                                     i_valid,
    input  wire gcm_aes_pkg::gcm_msg_t                    i_msg,
    input  wire logic [`GCM_NB_IV-1:0]                    i_iv,
    input  wire gcm_aes_pkg::aes_block_t                  i_h,
    input  wire logic                                     i_h_valid,
    input  wire logic                                     i_aes_done,
    input  wire gcm_aes_pkg::aes_block_t                  i_aes_block,
    input  wire gcm_aes_pkg::aes_block_t                  i_mult_z,
    output logic                                          o_aes_start,
    output gcm_aes_pkg::aes_block_t                       o_aes_block,
    output logic                                          o_h_store,
    output gcm_aes_pkg::aes_block_t                       o_mult_x,
    output gcm_aes_pkg::aes_block_t                       o_mult_h,
    output logic                                          o_busy,
    output logic                                          o_valid,
    output logic [`GCM_N_BLOCKS*`GCM_NB_BLOCK-1:0]        o_ciphertext,
    output gcm_aes_pkg::aes_block_t                       o_tag
);

    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_HKEY    = 4'd1;   // E(K, 0) for the hash subkey
    localparam logic [3:0] S_HWAIT   = 4'd2;
    localparam logic [3:0] S_J0      = 4'd3;
    localparam logic [3:0] S_J0WAIT  = 4'd4;
    localparam logic [3:0] S_AAD     = 4'd5;
    localparam logic [3:0] S_CTR     = 4'd6;
    localparam logic [3:0] S_CTRWAIT = 4'd7;
    localparam logic [3:0] S_LEN     = 4'd8;

    logic [3:0]                                 state_q;
    logic                                       blk_q;    // Plaintext block in flight
    gcm_aes_pkg::gcm_msg_t                      msg_q;
    gcm_aes_pkg::ctr_block_t                    ctr_q;
    gcm_aes_pkg::aes_block_t                    ej0_q;
    gcm_aes_pkg::aes_block_t                    acc_q;    // GHASH accumulator
    gcm_aes_pkg::aes_block_t                    pt_blk;
    gcm_aes_pkg::aes_block_t                    ct_blk;
    logic [`GCM_N_BLOCKS*`GCM_NB_BLOCK-1:0]     ct_q;
    logic [1:0]                                 n_pt;
    logic                                       has_aad;
    logic                                       last_pt;
    logic                                       accept;

    assign n_pt    = (msg_q.len_pt == 64'(`GCM_N_BLOCKS*`GCM_NB_BLOCK)) ? 2'd2 :
                     (msg_q.len_pt == 64'(`GCM_NB_BLOCK))               ? 2'd1 : 2'd0;
    assign has_aad = (msg_q.len_aad != '0);
    assign last_pt = (2'({1'b0, blk_q}) + 2'd1 == n_pt);
    assign accept  = (state_q == S_IDLE) && i_valid && i_h_valid && !i_cfg_load;

    assign pt_blk = msg_q.plaintext[blk_q*`GCM_NB_BLOCK +: `GCM_NB_BLOCK];
    assign ct_blk = pt_blk ^ i_aes_block;      // Keystream applied in the done cycle

    assign o_aes_start = (state_q == S_HKEY) || (state_q == S_J0) || (state_q == S_CTR);
    assign o_aes_block = (state_q == S_HKEY) ? '0 : ctr_q.raw;
    assign o_h_store   = (state_q == S_HWAIT) && i_aes_done;
    assign o_mult_h    = i_h;

    // Block folded this cycle as (acc ^ block) * H
    always_comb
    begin
        case (state_q)
            S_AAD:     o_mult_x = acc_q ^ msg_q.aad;
            S_CTRWAIT: o_mult_x = acc_q ^ ct_blk;
            default:   o_mult_x = acc_q ^ {msg_q.len_aad, msg_q.len_pt};
        endcase
    end

    always_ff @(posedge tb_i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q <= S_IDLE;
            blk_q   <= 1'b0;
            o_busy  <= 1'b0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= 1'b0;
            case (state_q)
                S_IDLE:
                begin
                    blk_q <= 1'b0;
                    if (i_cfg_load)
                    begin
                        state_q <= S_HKEY;
                        o_busy  <= 1'b1;
                    end
                    else if (accept)
                    begin
                        state_q <= S_J0;
                        o_busy  <= 1'b1;
                    end
                end
                S_HKEY:  state_q <= S_HWAIT;
                S_HWAIT:
                begin
                    if (i_aes_done)
                    begin
                        state_q <= S_IDLE;
                        o_busy  <= 1'b0;
                    end
                end
                S_J0:    state_q <= S_J0WAIT;
                S_J0WAIT:
                begin
                    if (i_aes_done)
                        state_q <= has_aad ? S_AAD : ((n_pt != 2'd0) ? S_CTR : S_LEN);
                end
                S_AAD:   state_q <= (n_pt != 2'd0) ? S_CTR : S_LEN;
                S_CTR:   state_q <= S_CTRWAIT;
                S_CTRWAIT:
                begin
                    if (i_aes_done)
                    begin
                        state_q <= last_pt ? S_LEN : S_CTR;
                        blk_q   <= 1'b1;
                    end
                end
                S_LEN:
                begin
                    state_q <= S_IDLE;
                    o_busy  <= 1'b0;
                    o_valid <= 1'b1;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge tb_i_clock)
    begin
        if (accept)
        begin
            msg_q       <= i_msg;
            ctr_q.f.iv  <= i_iv;
            ctr_q.f.ctr <= 32'd1;                           // J0 = IV || 1
            acc_q       <= '0;
            ct_q        <= '0;                              // Absent blocks read as zero
        end
        if ((state_q == S_J0WAIT) && i_aes_done)
        begin
            ej0_q       <= i_aes_block;
            ctr_q.f.ctr <= ctr_q.f.ctr + 32'd1;
        end
        if (state_q == S_AAD)
            acc_q <= i_mult_z;
        if ((state_q == S_CTRWAIT) && i_aes_done)
        begin
            ct_q[blk_q*`GCM_NB_BLOCK +: `GCM_NB_BLOCK] <= ct_blk;
            acc_q       <= i_mult_z;
            ctr_q.f.ctr <= ctr_q.f.ctr + 32'd1;
        end
        if (state_q == S_LEN)
        begin
            o_ciphertext <= ct_q;
            o_tag        <= i_mult_z ^ ej0_q;              // GHASH ^ E(K, J0)
        end
    end

endmodule

`default_nettype wire

//--- src/ghash_mult.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module ghash_mult (
    input  wire gcm_aes_pkg::aes_block_t  i_x,
    input  wire gcm_aes_pkg::aes_block_t  i_h,
    output gcm_aes_pkg::aes_block_t       o_z
);

    gcm_aes_pkg::aes_block_t z;
    gcm_aes_pkg::aes_block_t v;

    // Bit 0 of the GCM spec is the MSB of the word
    always_comb
    begin
        z = '0;
        v = i_h;
        for (int i = 0; i < `GCM_NB_BLOCK; i++)
        begin
            if (i_x[`GCM_NB_BLOCK-1-i])
                z = z ^ v;
            v = gcm_aes_pkg::gf128_shift(v);
        end
    end

    assign o_z = z;

endmodule

`default_nettype wire

//--- src/aes256_round_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module aes256_round_engine (
    input  wire logic                     tb_i_clock,
    input  wire logic                     i_arst_n,
    input  wire logic                     i_start,
    input  wire gcm_aes_pkg::aes_block_t  i_block,
    input  wire logic [`GCM_NB_KEY-1:0]   i_key,
    output logic                          o_done,
    output gcm_aes_pkg::aes_block_t       o_block
);

    gcm_aes_pkg::aes_block_t state_q;
    gcm_aes_pkg::aes_block_t round_in;
    gcm_aes_pkg::aes_block_t sub_shift;
    gcm_aes_pkg::aes_block_t mixed;
    gcm_aes_pkg::aes_block_t round_out;
    logic [`GCM_NB_BLOCK-1:0] key_prev_q;      // Round key r-2
    logic [`GCM_NB_BLOCK-1:0] key_cur_q;       // Round key r-1
    logic [`GCM_NB_BLOCK-1:0] next_key;
    logic [`GCM_NB_BLOCK-1:0] round_key;
    logic [31:0]              key_tmp;
    logic [7:0]               rcon;
    logic [7:0]               col_b [0:3];
    logic [3:0]               rnd_q;           // Round applied at the next edge
    logic                     run_q;
    logic                     last;

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {gcm_aes_pkg::aes_sbox(w[31:24]), gcm_aes_pkg::aes_sbox(w[23:16]),
                gcm_aes_pkg::aes_sbox(w[15:8]), gcm_aes_pkg::aes_sbox(w[7:0])};
    endfunction

    // Even rounds take RotWord and Rcon, odd rounds only SubWord
    always_comb
    begin
        rcon    = 8'h01 << (rnd_q[3:1] - 3'd1);
        key_tmp = key_cur_q[31:0];
        if (!rnd_q[0])
            key_tmp = sub_word({key_tmp[23:0], key_tmp[31:24]}) ^ {rcon, 24'd0};
        else
            key_tmp = sub_word(key_tmp);
        next_key[127:96] = key_prev_q[127:96] ^ key_tmp;
        next_key[95:64]  = key_prev_q[95:64] ^ next_key[127:96];
        next_key[63:32]  = key_prev_q[63:32] ^ next_key[95:64];
        next_key[31:0]   = key_prev_q[31:0] ^ next_key[63:32];
    end

    // The start cycle whitens with round key 0 and runs round 1 at once
    always_comb
    begin
        round_in  = i_start ? (i_block ^ i_key[`GCM_NB_BLOCK-1:0]) : state_q;
        round_key = i_start ? i_key[`GCM_NB_KEY-1:`GCM_NB_BLOCK] : next_key;
        last      = !i_start && run_q && (rnd_q == 4'(`AES_N_ROUNDS));
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                sub_shift[127 - 8*(4*c + r) -: 8] =
                    gcm_aes_pkg::aes_sbox(round_in[127 - 8*(4*((c + r) % 4) + r) -: 8]);
        end
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                col_b[r] = sub_shift[127 - 8*(4*c + r) -: 8];
            for (int r = 0; r < 4; r++)
                mixed[127 - 8*(4*c + r) -: 8] = gcm_aes_pkg::gf8_mul(col_b[r], 8'h02)
                    ^ gcm_aes_pkg::gf8_mul(col_b[(r + 1) % 4], 8'h03)
                    ^ col_b[(r + 2) % 4] ^ col_b[(r + 3) % 4];
        end
        round_out = (last ? sub_shift : mixed) ^ round_key;   // No MixColumns in round 14
    end

    always_ff @(posedge tb_i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            run_q  <= 1'b0;
            rnd_q  <= 4'd0;
            o_done <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                run_q <= 1'b1;
                rnd_q <= 4'd2;
            end
            else if (run_q)
            begin
                rnd_q <= rnd_q + 4'd1;
                if (last)
                begin
                    run_q  <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge tb_i_clock)
    begin
        if (i_start || run_q)
        begin
            state_q    <= round_out;
            key_prev_q <= i_start ? i_key[`GCM_NB_BLOCK-1:0] : key_cur_q;
            key_cur_q  <= round_key;
        end
    end

    assign o_block = state_q;   // Final ciphertext while o_done is high

endmodule

`default_nettype wire

//--- src/gcm_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "gcm_aes_defs.svh"

module gcm_cfg_regs (
    input  wire logic                     tb_i_clock,
    input  wire logic                     i_arst_n,
    input  wire logic                     i_cfg_load,
    input  wire gcm_aes_pkg::gcm_cfg_t    i_cfg,
    input  wire logic                     i_h_store,
    input  wire gcm_aes_pkg::aes_block_t  i_h,
    output logic [`GCM_NB_KEY-1:0]        o_key,
    output logic [`GCM_NB_IV-1:0]         o_iv,
    output gcm_aes_pkg::aes_block_t       o_h,
    output logic                          o_h_valid
);

    gcm_aes_pkg::gcm_cfg_t cfg_q;

    // H goes stale on every load until the sequencer stores the new one
    always_ff @(posedge tb_i_clock or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_h_valid <= 1'b0;
        else if (i_cfg_load)
            o_h_valid <= 1'b0;
        else if (i_h_store)
            o_h_valid <= 1'b1;
    end

    always_ff @(posedge tb_i_clock)
    begin
        if (i_cfg_load)
            cfg_q <= i_cfg;
        if (i_h_store)
            o_h <= i_h;         // E(K, 0^128) from the engine
    end

    assign o_key = cfg_q.key;
    assign o_iv  = cfg_q.iv;

endmodule

`default_nettype wire

//--- src/gcm_aes_pkg.sv
`default_nettype none
`include "gcm_aes_defs.svh"

package gcm_aes_pkg;

    typedef logic [`GCM_NB_BLOCK-1:0] aes_block_t;      // Byte 0 in the top bits

    typedef struct packed {
        logic [`GCM_NB_IV-1:0]               iv;
        logic [`GCM_NB_BLOCK-`GCM_NB_IV-1:0] ctr;       // inc32 field
    } ctr_fields_t;

    typedef union packed {
        aes_block_t  raw;                               // View fed to the engine
        ctr_fields_t f;
    } ctr_block_t;

    typedef struct packed {
        logic [`GCM_NB_KEY-1:0] key;                    // First half in the low bits
        logic [`GCM_NB_IV-1:0]  iv;
    } gcm_cfg_t;

    typedef struct packed {
        aes_block_t                               aad;
        logic [`GCM_N_BLOCKS*`GCM_NB_BLOCK-1:0]   plaintext;  // Block 0 in the low half
        logic [`GCM_NB_LEN-1:0]                   len_aad;
        logic [`GCM_NB_LEN-1:0]                   len_pt;
    } gcm_msg_t;

    // Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] gf8_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // Inverse as a^254, then the affine map
    function automatic logic [7:0] aes_sbox(input logic [7:0] a);
        logic [7:0] sq;
        logic [7:0] b;
        sq = a;
        b  = 8'h01;
        for (int k = 1; k < 8; k++)
        begin
            sq = gf8_mul(sq, sq);   // a^(2^k)
            b  = gf8_mul(b, sq);
        end
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
                 ^ {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    // One step of V * x in the reflected GCM order, reduced by R = 0xE1 || 0^120
    function automatic aes_block_t gf128_shift(input aes_block_t v);
        return {1'b0, v[`GCM_NB_BLOCK-1:1]}
             ^ ({8'he1, {(`GCM_NB_BLOCK-8){1'b0}}} & {`GCM_NB_BLOCK{v[0]}});
    endfunction

endpackage

`default_nettype wire

//--- src/gcm_aes_defs.svh
`ifndef GCM_AES_DEFS_SVH
`define GCM_AES_DEFS_SVH

`define GCM_NB_BLOCK    128     // AES block and GHASH element
`define GCM_NB_KEY      256     // AES-256 key
`define GCM_NB_IV       96      // Only 96-bit IVs are handled
`define GCM_NB_LEN      64      // Bit length fields of the length block
`define GCM_N_BLOCKS    2       // Plaintext blocks per message
`define AES_N_ROUNDS    14

`endif
